/* all.f */
+incdir+rtl
rtl/mem_bus_pkg.sv
rtl/arb_pkg.sv
rtl/mem_arbiter.sv
rtl/line_memory.sv
rtl/mem_subsys_top.sv
sim/tb_clock_gen.sv
sim/mem_subsys_properties.sv
sim/mem_subsys_tb.sv

/* run.sh */
#!/bin/bash
# build the memory subsystem testbench with Verilator, run it,
# and fail when the log holds the fail message
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal -f all.f --top-module mem_subsys_tb \
    -o mem_subsys_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/mem_subsys_sim > sim.log 2>&1 || echo "simulation ended with an error status" >> sim.log
cat sim.log
grep -q "TEST RESULT: FAIL" sim.log && exit 1
grep -q "TEST RESULT: PASS" sim.log || exit 1
exit 0

/* sim/mem_subsys_tests.txt */
# name port(i/d) op(r/w) addr wdata expected_line conc
# conc: 0 alone, 1 with next line in the same cycle, n>1 next line n-1 cycles later
wr_a       d w 100 a5a5a5a5000000011111111122222222 a5a5a5a5000000011111111122222222 0
rd_a       d r 100 0 a5a5a5a5000000011111111122222222 0
ird_a      i r 100 0 a5a5a5a5000000011111111122222222 0
wr_b       d w 200 0123456789abcdeffedcba9876543210 0123456789abcdeffedcba9876543210 0
wr_c       d w 300 deadbeefcafef00d0badc0de12345678 deadbeefcafef00d0badc0de12345678 0
both_d_b   d r 200 0 0123456789abcdeffedcba9876543210 1
both_i_c   i r 300 0 deadbeefcafef00d0badc0de12345678 0
fly_i_a    i r 100 0 a5a5a5a5000000011111111122222222 3
fly_d_b    d r 200 0 0123456789abcdeffedcba9876543210 0
both_d_wd  d w 400 5555aaaa5555aaaa0f0f0f0ff0f0f0f0 5555aaaa5555aaaa0f0f0f0ff0f0f0f0 1
both_i_d   i r 400 0 5555aaaa5555aaaa0f0f0f0ff0f0f0f0 0
wr_idx0    d w 000 00e000000000000100e0000000000002 00e000000000000100e0000000000002 0
wr_idx1    d w 010 00e100000000000100e1000000000002 00e100000000000100e1000000000002 0
wr_idx2    d w 020 00e200000000000100e2000000000002 00e200000000000100e2000000000002 0
wr_idx255  d w ff0 00e300000000000100e3000000000002 00e300000000000100e3000000000002 0
rd_idx0    d r 000 0 00e000000000000100e0000000000002 0
rd_idx1    i r 010 0 00e100000000000100e1000000000002 0
rd_idx2    d r 020 0 00e200000000000100e2000000000002 0
rd_idx255  i r ff0 0 00e300000000000100e3000000000002 0
lag_d_c    d r 300 0 deadbeefcafef00d0badc0de12345678 2
lag_i_b    i r 200 0 0123456789abcdeffedcba9876543210 0
both_i_e0  i r 000 0 00e000000000000100e0000000000002 1
both_d_e1  d r 010 0 00e100000000000100e1000000000002 0
wr_a2      d w 100 f00df00df00df00d1234432112344321 f00df00df00df00d1234432112344321 0
ird_a2     i r 100 0 f00df00df00df00d1234432112344321 0
fly_i_e3   i r ff0 0 00e300000000000100e3000000000002 2
fly_d_e2   d r 020 0 00e200000000000100e2000000000002 0

/* sim/mem_subsys_tb.sv */
// ****************************************
// memory subsystem testbench
// runs the tests file on both cache ports
// ****************************************
`timescale 1ns/100ps
`include "mem_defs.svh"

module mem_subsys_tb import mem_bus_pkg::*, arb_pkg::*; ();

    localparam int MAX_TESTS = 64;
    localparam int XFER_CYCLES = `MEM_WAIT_CYCLES + `LINE_BEATS + 6;

    logic clk;
    logic rst;
    logic [`ADDR_W-1:0] i_addr;
    logic               i_valid;
    logic [`LINE_W-1:0] i_rdata;
    logic               i_ready;
    logic [`ADDR_W-1:0] d_addr;
    mem_op_e            d_op;
    logic               d_valid;
    logic [`LINE_W-1:0] d_wdata;
    logic [`LINE_W-1:0] d_rdata;
    logic               d_ready;

    // test table
    logic [8*20-1:0]    t_name  [MAX_TESTS];
    logic               t_dport [MAX_TESTS]; // 1 for the dcache port
    mem_op_e            t_op    [MAX_TESTS];
    logic [`ADDR_W-1:0] t_addr  [MAX_TESTS];
    logic [`LINE_W-1:0] t_wdata [MAX_TESTS];
    logic [`LINE_W-1:0] t_exp   [MAX_TESTS];
    int                 t_conc  [MAX_TESTS];
    int                 n_tests;

    grant_e order_q[$];   // ports in order of ready arrival
    int     cycles = 0;
    int     cycle_limit = 0;

    tb_clock_gen i_tb_clock_gen (.clk_o(clk), .rst_o(rst));

    mem_subsys_top i_mem_subsys_top (
        .clk       (clk),
        .rst       (rst),
        .i_addr_i  (i_addr),
        .i_valid_i (i_valid),
        .i_rdata_o (i_rdata),
        .i_ready_o (i_ready),
        .d_addr_i  (d_addr),
        .d_op_i    (d_op),
        .d_valid_i (d_valid),
        .d_wdata_i (d_wdata),
        .d_rdata_o (d_rdata),
        .d_ready_o (d_ready)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic check_line(input logic [8*20-1:0] name, input logic [`LINE_W-1:0] exp,
                              input logic [`LINE_W-1:0] act);
        if (act !== exp) begin
            abort_run($sformatf("error %0s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_grant(input logic [8*20-1:0] name, input grant_e exp,
                               input grant_e act);
        if (act !== exp) begin
            abort_run($sformatf("error %0s: expected first ready %s, actual %s",
                                name, exp.name(), act.name()));
        end
    endtask

    task automatic load_tests();
        int               fd;
        int               n;
        logic [8*128-1:0] line_buf;
        logic [7:0]       port_c;
        logic [7:0]       op_c;
        fd = $fopen("sim/mem_subsys_tests.txt", "r");
        if (fd == 0) abort_run("cannot open sim/mem_subsys_tests.txt");
        n_tests = 0;
        while (!$feof(fd) && n_tests < MAX_TESTS) begin
            line_buf = '0;
            void'($fgets(line_buf, fd));
            n = $sscanf(line_buf, "%s %s %s %h %h %h %d", t_name[n_tests], port_c, op_c,
                        t_addr[n_tests], t_wdata[n_tests], t_exp[n_tests], t_conc[n_tests]);
            if (n == 7 && t_name[n_tests] != "#") begin
                if (port_c == "i" && op_c == "w") abort_run("icache test line asks for a write");
                t_dport[n_tests] = (port_c == "d");
                t_op[n_tests]    = (op_c == "w") ? MEM_WRITE : MEM_READ;
                n_tests++;
            end
        end
        $fclose(fd);
    endtask

    // n rising edges, then the drive point after the edge
    task automatic wait_cycles(input int n);
        if (n > 0) begin
            repeat (n) @(posedge clk);
            #2;
        end
    endtask

    // one request on its port, held until ready
    task automatic serve(input int t, input int delay);
        wait_cycles(delay);
        if (t_dport[t]) begin
            d_addr  = t_addr[t];
            d_op    = t_op[t];
            d_wdata = t_wdata[t];
            d_valid = 1'b1;
            do @(negedge clk); while (!d_ready);
            order_q.push_back(GRANT_DCACHE);
            check_line(t_name[t], t_exp[t], d_rdata); // a write returns the stored line
            wait_cycles(1);
            d_valid = 1'b0;
        end else begin
            i_addr  = t_addr[t];
            i_valid = 1'b1;
            do @(negedge clk); while (!i_ready);
            order_q.push_back(GRANT_ICACHE);
            check_line(t_name[t], t_exp[t], i_rdata);
            wait_cycles(1);
            i_valid = 1'b0;
        end
    endtask

    // a port sees ready only while it requests
    always @(negedge clk) begin
        if (!rst && ((i_ready && !i_valid) || (d_ready && !d_valid))) begin
            abort_run("ready pulse on a port that had no request");
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            abort_run("timeout, the tests did not finish within the cycle limit");
        end
    end

    initial begin
        int     idle;
        grant_e exp_first;
        void'($urandom(32'h6cb6aa58));
        i_addr  = '0;
        i_valid = 1'b0;
        d_addr  = '0;
        d_op    = MEM_READ;
        d_valid = 1'b0;
        d_wdata = '0;
        load_tests();
        cycle_limit = n_tests * 2 * XFER_CYCLES + 100;
        @(negedge rst);
        for (int t = 0; t < n_tests; t++) begin
            idle = $urandom % 4;
            wait_cycles(idle);
            order_q.delete();
            if (t_conc[t] > 0) begin
                if (t + 1 >= n_tests || t_dport[t] == t_dport[t+1]) begin
                    abort_run("a paired test needs a next line on the other port");
                end
                fork
                    serve(t, 0);
                    serve(t + 1, t_conc[t] - 1);
                join
                // same cycle goes to dcache, otherwise the earlier request
                if (t_conc[t] == 1) exp_first = GRANT_DCACHE;
                else exp_first = t_dport[t] ? GRANT_DCACHE : GRANT_ICACHE;
                check_grant(t_name[t], exp_first, order_q[0]);
                t++;
            end else begin
                serve(t, 0);
            end
        end
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

/* sim/mem_subsys_properties.sv */
// ****************************************
// handshake properties for one
// valid/ready pair of the memory subsystem
// ****************************************
`timescale 1ns/100ps

module mem_subsys_properties #(
    parameter bit valid_reset_low = 1'b0 // set where valid is a registered output
) (
    input logic clk,
    input logic rst,
    input logic valid_i,
    input logic ready_i
);

    a_ready_one_cycle: assert property (@(posedge clk) disable iff (rst)
        ready_i |=> !ready_i)
        else $error("ready held longer than one cycle");

    a_valid_held: assert property (@(posedge clk) disable iff (rst)
        valid_reset_low && valid_i && !ready_i |=> valid_i)
        else $error("valid dropped before its ready");

    a_ready_needs_valid: assert property (@(posedge clk) disable iff (rst)
        ready_i |-> valid_i)
        else $error("ready without a valid request");

    a_quiet_after_reset: assert property (@(posedge clk)
        rst |=> !ready_i && !(valid_reset_low && valid_i))
        else $error("handshake active right after reset");

endmodule

// both cache ports at the arbiter, the channel at the store
bind mem_arbiter mem_subsys_properties i_icache_props (
    .clk(clk), .rst(rst), .valid_i(i_valid_i), .ready_i(i_ready_o));
bind mem_arbiter mem_subsys_properties i_dcache_props (
    .clk(clk), .rst(rst), .valid_i(d_valid_i), .ready_i(d_ready_o));
bind line_memory mem_subsys_properties #(.valid_reset_low(1'b1)) i_channel_props (
    .clk(clk), .rst(rst), .valid_i(rw_valid_i), .ready_i(rw_ready_o));

/* sim/tb_clock_gen.sv */
// ****************************************
// testbench clock and reset
// 20 ns period, reset held 8 cycles
// ****************************************
`timescale 1ns/100ps

module tb_clock_gen (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #10 clk_o = ~clk_o;
    end

    initial begin
        rst_o = 1'b1;
        repeat (8) @(posedge clk_o);
        #2 rst_o = 1'b0; // released with the other inputs
    end

endmodule

/* rtl/mem_subsys_top.sv */
// ****************************************
// memory subsystem top
// arbiter in front of the line store
// ****************************************
`timescale 1ns/100ps
`include "mem_defs.svh"

module mem_subsys_top import mem_bus_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic [`ADDR_W-1:0] i_addr_i,
    input  logic               i_valid_i,
    output logic [`LINE_W-1:0] i_rdata_o,
    output logic               i_ready_o,
    input  logic [`ADDR_W-1:0] d_addr_i,
    input  mem_op_e            d_op_i,
    input  logic               d_valid_i,
    input  logic [`LINE_W-1:0] d_wdata_i,
    output logic [`LINE_W-1:0] d_rdata_o,
    output logic               d_ready_o
);

    // memory channel
    logic [`ADDR_W-1:0] rw_addr;
    mem_op_e            rw_op;
    logic               rw_valid;
    logic [`LINE_W-1:0] rw_wdata;
    logic [`LINE_W-1:0] rw_rdata;
    logic               rw_ready;

    mem_arbiter i_mem_arbiter (
        .clk        (clk),
        .rst        (rst),
        .i_addr_i   (i_addr_i),
        .i_valid_i  (i_valid_i),
        .i_rdata_o  (i_rdata_o),
        .i_ready_o  (i_ready_o),
        .d_addr_i   (d_addr_i),
        .d_op_i     (d_op_i),
        .d_valid_i  (d_valid_i),
        .d_wdata_i  (d_wdata_i),
        .d_rdata_o  (d_rdata_o),
        .d_ready_o  (d_ready_o),
        .rw_addr_o  (rw_addr),
        .rw_op_o    (rw_op),
        .rw_valid_o (rw_valid),
        .rw_wdata_o (rw_wdata),
        .rw_rdata_i (rw_rdata),
        .rw_ready_i (rw_ready)
    );

    line_memory i_line_memory (
        .clk        (clk),
        .rst        (rst),
        .rw_addr_i  (rw_addr),
        .rw_op_i    (rw_op),
        .rw_valid_i (rw_valid),
        .rw_wdata_i (rw_wdata),
        .rw_rdata_o (rw_rdata),
        .rw_ready_o (rw_ready)
    );

endmodule

/* rtl/line_memory.sv */
// ****************************************
// line-wide backing store
// wait states, two beats per line,
// one-cycle ready pulse with the line
// ****************************************
`timescale 1ns/100ps
`include "mem_defs.svh"

module line_memory import mem_bus_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic [`ADDR_W-1:0] rw_addr_i,
    input  mem_op_e            rw_op_i,
    input  logic               rw_valid_i,
    input  logic [`LINE_W-1:0] rw_wdata_i,
    output logic [`LINE_W-1:0] rw_rdata_o,
    output logic               rw_ready_o
);

    localparam int LINE_OFF_W = $clog2(`LINE_W / 8);    // byte offset in a line
    localparam int IDX_W      = $clog2(`MEM_LINES);
    localparam int BEAT_SEL_W = $clog2(`LINE_BEATS);
    localparam int WAIT_CNT_W = $clog2(`MEM_WAIT_CYCLES + 1);
    localparam int WORDS      = `MEM_LINES * `LINE_BEATS;

    logic [`BEAT_W-1:0] mem [WORDS];

    mem_state_e            state_q;
    logic [WAIT_CNT_W-1:0] wait_cnt_q;
    logic [BEAT_SEL_W-1:0] beat_q;

    // captured request
    logic [IDX_W-1:0]      idx_q;
    mem_op_e               op_q;
    logic [`LINE_W-1:0]    wline_q;
    logic [`LINE_W-1:0]    rbuf_q;    // line assembled beat by beat

    logic [IDX_W+BEAT_SEL_W-1:0] word_addr;

    assign word_addr = {idx_q, beat_q};

    // tests write before they read
    initial begin
        for (int i = 0; i < WORDS; i++) begin
            mem[i] = '0;
        end
    end

    // sequencer
    always_ff @(posedge clk) begin
        if (rst) begin
            state_q    <= MEM_IDLE;
            wait_cnt_q <= '0;
            beat_q     <= '0;
        end else begin
            case (state_q)
                MEM_IDLE: begin
                    if (rw_valid_i) begin
                        state_q    <= MEM_WAIT;
                        wait_cnt_q <= '0;
                    end
                end
                MEM_WAIT: begin
                    if (wait_cnt_q == WAIT_CNT_W'(`MEM_WAIT_CYCLES - 1)) begin
                        state_q <= MEM_BEAT;
                        beat_q  <= '0;
                    end else begin
                        wait_cnt_q <= wait_cnt_q + 1'b1;
                    end
                end
                MEM_BEAT: begin
                    if (beat_q == BEAT_SEL_W'(`LINE_BEATS - 1)) begin
                        state_q <= MEM_DONE;
                    end else begin
                        beat_q <= beat_q + 1'b1;
                    end
                end
                MEM_DONE: state_q <= MEM_IDLE; // rw_valid drops next edge
                default:  state_q <= MEM_IDLE;
            endcase
        end
    end

    // capture request when it is first seen
    always_ff @(posedge clk) begin
        if (state_q == MEM_IDLE && rw_valid_i) begin
            idx_q   <= rw_addr_i[LINE_OFF_W +: IDX_W];
            op_q    <= rw_op_i;
            wline_q <= rw_wdata_i;
        end
    end

    // one beat per cycle
    always_ff @(posedge clk) begin
        if (state_q == MEM_BEAT) begin
            if (op_q == MEM_WRITE) begin
                mem[word_addr]                  <= wline_q[beat_q*`BEAT_W +: `BEAT_W];
                rbuf_q[beat_q*`BEAT_W +: `BEAT_W] <= wline_q[beat_q*`BEAT_W +: `BEAT_W];
            end else begin
                rbuf_q[beat_q*`BEAT_W +: `BEAT_W] <= mem[word_addr];
            end
        end
    end

    assign rw_ready_o = (state_q == MEM_DONE);
    assign rw_rdata_o = rbuf_q; // a write echoes the stored line

endmodule

/* rtl/mem_arbiter.sv */
// ****************************************
// two-port cache arbiter
// dcache first, one transfer at a time,
// ready steered by registered grant
// ****************************************
`timescale 1ns/100ps
`include "mem_defs.svh"

module mem_arbiter import mem_bus_pkg::*, arb_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    // icache port, read only
    input  logic [`ADDR_W-1:0] i_addr_i,
    input  logic               i_valid_i,
    output logic [`LINE_W-1:0] i_rdata_o,
    output logic               i_ready_o,
    // dcache port
    input  logic [`ADDR_W-1:0] d_addr_i,
    input  mem_op_e            d_op_i,
    input  logic               d_valid_i,
    input  logic [`LINE_W-1:0] d_wdata_i,
    output logic [`LINE_W-1:0] d_rdata_o,
    output logic               d_ready_o,
    // memory channel
    output logic [`ADDR_W-1:0] rw_addr_o,
    output mem_op_e            rw_op_o,
    output logic               rw_valid_o,
    output logic [`LINE_W-1:0] rw_wdata_o,
    input  logic [`LINE_W-1:0] rw_rdata_i,
    input  logic               rw_ready_i
);

    arb_state_e state_q;
    grant_e     grant_q;
    logic       any_valid;
    logic       accept;

    assign any_valid = i_valid_i | d_valid_i;
    assign accept    = (state_q == ARB_IDLE) && any_valid;

    // state and channel valid
    always_ff @(posedge clk) begin
        if (rst) begin
            state_q    <= ARB_IDLE;
            rw_valid_o <= 1'b0;
            grant_q    <= GRANT_ICACHE;
        end else begin
            case (state_q)
                ARB_IDLE: begin
                    if (any_valid) begin
                        state_q    <= ARB_BUSY;
                        rw_valid_o <= 1'b1;
                        grant_q    <= d_valid_i ? GRANT_DCACHE : GRANT_ICACHE;
                    end
                end
                ARB_BUSY: begin
                    // no new request in the pulse cycle
                    if (rw_ready_i) begin
                        state_q    <= ARB_IDLE;
                        rw_valid_o <= 1'b0;
                    end
                end
                default: begin
                    state_q    <= ARB_IDLE;
                    rw_valid_o <= 1'b0;
                end
            endcase
        end
    end

    // request payload, held for the whole transfer
    always_ff @(posedge clk) begin
        if (accept) begin
            if (d_valid_i) begin
                rw_addr_o <= d_addr_i;
                rw_op_o   <= d_op_i;
            end else begin
                rw_addr_o <= i_addr_i;
                rw_op_o   <= MEM_READ; // icache never writes
            end
        end
    end

    // dcache holds wdata until its ready
    assign rw_wdata_o = d_wdata_i;

    // steer by the stored owner, not by the live valids
    assign i_ready_o = rw_ready_i && (grant_q == GRANT_ICACHE);
    assign d_ready_o = rw_ready_i && (grant_q == GRANT_DCACHE);
    assign i_rdata_o = (grant_q == GRANT_ICACHE) ? rw_rdata_i : '0;
    assign d_rdata_o = (grant_q == GRANT_DCACHE) ? rw_rdata_i : '0;

endmodule

/* rtl/arb_pkg.sv */
// ****************************************
// arbitration types
// arbiter state and transfer owner
// ****************************************
package arb_pkg;

    typedef enum logic {
        ARB_IDLE = 1'b0,
        ARB_BUSY = 1'b1
    } arb_state_e;

    // owner of the transfer in flight
    typedef enum logic {
        GRANT_ICACHE = 1'b0,
        GRANT_DCACHE = 1'b1
    } grant_e;

endpackage

/* rtl/mem_bus_pkg.sv */
// ****************************************
// memory channel types
// access operation and sequencer states
// ****************************************
package mem_bus_pkg;

    // operation on dcache port and memory channel
    typedef enum logic {
        MEM_READ  = 1'b0,
        MEM_WRITE = 1'b1
    } mem_op_e;

    typedef enum logic [1:0] {
        MEM_IDLE = 2'd0,
        MEM_WAIT = 2'd1, // counting wait states
        MEM_BEAT = 2'd2, // one beat per cycle
        MEM_DONE = 2'd3  // ready pulse
    } mem_state_e;

endpackage

/* rtl/mem_defs.svh */
// ****************************************
// memory subsystem widths and timing
// shared by the arbiter, store and top
// ****************************************
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

`define ADDR_W          64
`define LINE_W          128
`define BEAT_W          64
`define LINE_BEATS      2
`define MEM_LINES       256 // depth in lines
`define MEM_WAIT_CYCLES 3   // idle cycles before first beat

`endif
